// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
TOP       = heapMemoryTb
FILELIST  = compile.f
BUILD     = obj_dir
LOG       = sim.log
PASS      = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: compile.f
hw/heapGeometryPkg.sv
hw/heapCommandPkg.sv
hw/heapAllocator.sv
hw/heapSizeTable.sv
hw/heapElementAlu.sv
hw/heapController.sv
hw/heapMemory.sv
tests/heapMemoryTb.sv

// File: hw/heapAllocator.sv
// Array allocator
// Hands out fresh handles in order and reuses freed ones last in, first out

module heapAllocator (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        allocate,              // Take grantHandle
  input  logic                        releaseHandle,         // Return queryHandle
  input  logic                        clear,                 // Forget everything
  input  heapGeometryPkg::arrayHandle queryHandle,
  output logic                        live,
  output logic                        fresh,
  output heapGeometryPkg::arrayHandle grantHandle,
  output logic                        exhausted
);

  logic [heapGeometryPkg::addressBits:0]  issuedCount;      // Handles ever given out
  logic [heapGeometryPkg::addressBits:0]  freedTop;         // Entries on the freed stack
  logic [heapGeometryPkg::arrayCount-1:0] allocated;        // One flag per array
  heapGeometryPkg::arrayHandle freedStack [heapGeometryPkg::arrayCount];
  heapGeometryPkg::arrayHandle stackTopIndex;

  assign stackTopIndex = heapGeometryPkg::arrayHandle'(freedTop - 1'b1);
  assign fresh         = {1'b0, queryHandle} >= issuedCount; // Never handed out
  assign live          = allocated[queryHandle];
  assign exhausted     = (freedTop == '0) && (issuedCount == heapGeometryPkg::arrayCount);

  // Reuse first, otherwise the next untouched handle
  assign grantHandle = (freedTop != '0) ? freedStack[stackTopIndex]
                                        : issuedCount[heapGeometryPkg::addressBits-1:0];

  //--------------------------------------------------------------------------
  // Bookkeeping
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      issuedCount <= '0;
      freedTop    <= '0;
      allocated   <= '0;
    end else begin
      if (allocate) begin
        allocated[grantHandle] <= 1'b1;
        if (freedTop != '0) begin
          freedTop <= freedTop - 1'b1;                      // Pop the reused handle
        end else begin
          issuedCount <= issuedCount + 1'b1;                // Step to next fresh handle
        end
      end
      if (releaseHandle) begin
        allocated[queryHandle] <= 1'b0;
        freedTop               <= freedTop + 1'b1;
      end
    end
  end

  // Stack payload, only live handles get released so it never overflows
  always_ff @(posedge clock) begin
    if (releaseHandle) begin
      freedStack[freedTop[heapGeometryPkg::addressBits-1:0]] <= queryHandle;
    end
  end

endmodule

// File: hw/heapCommandPkg.sv
// Heap command set
// Action codes, error codes, size table updates and the request and response words

package heapCommandPkg;

  // Original action codes kept so existing command streams still decode
  typedef enum logic [7:0] {
    idle       = 8'd0,                                      // No command this cycle
    clearAll   = 8'd1,                                      // Forget every array
    write      = 8'd2,                                      // Store element, may grow array
    read       = 8'd3,                                      // Fetch element
    size       = 8'd4,                                      // Report array size
    push       = 8'd14,                                     // Append at the top
    pop        = 8'd15,                                     // Remove from the top
    resize     = 8'd17,                                     // Set size directly
    alloc      = 8'd18,                                     // Hand out an array
    free       = 8'd19,                                     // Return an array
    add        = 8'd20,                                     // Report new value
    addAfter   = 8'd21,                                     // Report old value
    subtract   = 8'd22,
    subAfter   = 8'd23,
    shiftLeft  = 8'd24,
    shiftRight = 8'd25,
    bitNot     = 8'd27,
    bitOr      = 8'd28,
    bitXor     = 8'd29,
    bitAnd     = 8'd30
  } heapAction;

  typedef enum logic [2:0] {
    none, notAllocated, freed, outOfBounds, full, empty, tooLarge, outOfMemory
  } heapError;

  typedef enum logic [2:0] {
    keep, setValue, increment, decrement, zero
  } sizeUpdate;

  typedef struct packed {
    heapAction                   action;                    // What to do
    heapGeometryPkg::arrayHandle  array;                    // Target array
    heapGeometryPkg::elementIndex index;                    // Target element
    heapGeometryPkg::elementData  data;                     // Operand or value
  } heapRequest;                                            // 30 bits

  typedef struct packed {
    heapGeometryPkg::elementData data;                      // Result of last good command
    heapError                    error;                     // Outcome of last command
  } heapResponse;                                           // 19 bits

endpackage

// File: hw/heapController.sv
// Heap controller
// Decodes each command, checks for errors, owns the element storage and
// registers the response at the edge that samples the command

module heapController (
  input  logic                        clock,
  input  logic                        reset,
  input  heapCommandPkg::heapRequest  request,
  output heapCommandPkg::heapResponse response,
  input  logic                        live,
  input  logic                        fresh,
  input  heapGeometryPkg::arrayHandle grantHandle,
  input  logic                        exhausted,
  output logic                        allocate,
  output logic                        releaseHandle,
  output logic                        clear,
  output heapGeometryPkg::arrayHandle queryHandle,
  input  heapGeometryPkg::arraySize   currentSize,
  output heapCommandPkg::sizeUpdate   sizeOp,
  output heapGeometryPkg::arrayHandle sizeHandle,
  output heapGeometryPkg::arraySize   sizeValue,
  output heapGeometryPkg::elementData storedElement,
  input  heapGeometryPkg::elementData aluElement,
  input  heapGeometryPkg::elementData aluReport
);

  heapGeometryPkg::elementData storage [heapGeometryPkg::arrayCount][heapGeometryPkg::arrayLength];
  heapGeometryPkg::elementIndex topIndex;                   // Last element of the array
  heapGeometryPkg::elementData  replyData;
  heapCommandPkg::heapError     error;
  logic                         known;                      // Action is one we execute
  logic                         handleChecked;
  logic                         arithmetic;
  logic                         ok;

  assign queryHandle   = request.array;
  assign storedElement = storage[request.array][request.index];
  assign topIndex      = heapGeometryPkg::elementIndex'(currentSize - 1'b1);

  //--------------------------------------------------------------------------
  // Decode and error checks, first match wins
  //--------------------------------------------------------------------------
  always_comb begin
    arithmetic = request.action inside {heapCommandPkg::add, heapCommandPkg::addAfter,
                 heapCommandPkg::subtract, heapCommandPkg::subAfter, heapCommandPkg::shiftLeft,
                 heapCommandPkg::shiftRight, heapCommandPkg::bitNot, heapCommandPkg::bitOr,
                 heapCommandPkg::bitXor, heapCommandPkg::bitAnd};
    known = arithmetic || request.action inside {heapCommandPkg::clearAll,
            heapCommandPkg::write, heapCommandPkg::read, heapCommandPkg::size,
            heapCommandPkg::push, heapCommandPkg::pop, heapCommandPkg::resize,
            heapCommandPkg::alloc, heapCommandPkg::free};
    handleChecked = known && !(request.action inside {heapCommandPkg::clearAll,
                                                      heapCommandPkg::alloc});
    error = heapCommandPkg::none;
    if (handleChecked && fresh)                              error = heapCommandPkg::notAllocated;
    else if (handleChecked && !live)                         error = heapCommandPkg::freed;
    else if ((arithmetic || request.action == heapCommandPkg::read)
             && {1'b0, request.index} >= currentSize)        error = heapCommandPkg::outOfBounds;
    else if (request.action == heapCommandPkg::push
             && currentSize == heapGeometryPkg::arrayLength) error = heapCommandPkg::full;
    else if (request.action == heapCommandPkg::pop && currentSize == '0)
      error = heapCommandPkg::empty;
    else if (request.action == heapCommandPkg::resize
             && request.data > heapGeometryPkg::arrayLength) error = heapCommandPkg::tooLarge;
    else if (request.action == heapCommandPkg::alloc && exhausted)
      error = heapCommandPkg::outOfMemory;
    ok = known && error == heapCommandPkg::none;
  end

  //--------------------------------------------------------------------------
  // Controls to allocator and size table, and the reply value
  //--------------------------------------------------------------------------
  always_comb begin
    allocate      = ok && request.action == heapCommandPkg::alloc;
    releaseHandle = ok && request.action == heapCommandPkg::free;
    clear         = request.action == heapCommandPkg::clearAll; // Never fails
    sizeOp     = heapCommandPkg::keep;
    sizeHandle = request.array;
    sizeValue  = heapGeometryPkg::arraySize'(request.index) + 1'b1;  // Write grows to index+1
    replyData  = aluReport;                                  // Arithmetic default
    case (request.action)
      heapCommandPkg::write: begin
        replyData = request.data;
        if (ok && {1'b0, request.index} >= currentSize) sizeOp = heapCommandPkg::setValue;
      end
      heapCommandPkg::read: replyData = storedElement;
      heapCommandPkg::size: replyData = heapGeometryPkg::elementData'(currentSize);
      heapCommandPkg::push: if (ok) sizeOp = heapCommandPkg::increment;
      heapCommandPkg::pop: begin
        replyData = storage[request.array][topIndex];
        if (ok) sizeOp = heapCommandPkg::decrement;
      end
      heapCommandPkg::resize: begin
        sizeValue = heapGeometryPkg::arraySize'(request.data);
        if (ok) sizeOp = heapCommandPkg::setValue;
      end
      heapCommandPkg::alloc: begin
        replyData  = heapGeometryPkg::elementData'(grantHandle);
        sizeHandle = grantHandle;                           // Reused arrays start empty
        if (ok) sizeOp = heapCommandPkg::zero;
      end
      default: ;
    endcase
  end

  //--------------------------------------------------------------------------
  // Response and element storage
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      response <= '0;                                       // Data 0, error none
    end else if (known) begin
      response.error <= error;
      if (ok && !(request.action inside {heapCommandPkg::clearAll, heapCommandPkg::push,
                                         heapCommandPkg::resize, heapCommandPkg::free})) begin
        response.data <= replyData;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ok) begin
      if (request.action == heapCommandPkg::write) begin
        storage[request.array][request.index] <= request.data;
      end else if (request.action == heapCommandPkg::push) begin
        storage[request.array][currentSize[heapGeometryPkg::indexBits-1:0]] <= request.data;
      end else if (arithmetic) begin
        storage[request.array][request.index] <= aluElement;  // Result in place
      end
    end
  end

endmodule

// File: hw/heapElementAlu.sv
// Element ALU
// In-place arithmetic on one element and the value each action reports

module heapElementAlu (
  input  heapCommandPkg::heapAction   action,
  input  heapGeometryPkg::elementData element,              // Stored value
  input  heapGeometryPkg::elementData operand,              // Request data
  output heapGeometryPkg::elementData newElement,
  output heapGeometryPkg::elementData report
);

  always_comb begin
    case (action)
      heapCommandPkg::add,
      heapCommandPkg::addAfter:   newElement = element + operand;
      heapCommandPkg::subtract,
      heapCommandPkg::subAfter:   newElement = element - operand;
      heapCommandPkg::shiftLeft:  newElement = element << operand;  // 16 or more gives 0
      heapCommandPkg::shiftRight: newElement = element >> operand;
      heapCommandPkg::bitNot:     newElement = ~element;
      heapCommandPkg::bitOr:      newElement = element | operand;
      heapCommandPkg::bitXor:     newElement = element ^ operand;
      heapCommandPkg::bitAnd:     newElement = element & operand;
      default:                    newElement = element;     // Not arithmetic
    endcase
  end

  // After forms hand back the value before the update
  assign report = (action == heapCommandPkg::addAfter || action == heapCommandPkg::subAfter)
                  ? element : newElement;

endmodule

// File: hw/heapGeometryPkg.sv
// Heap geometry
// Array count, array length and the widths of handles, indices, sizes and data

package heapGeometryPkg;

  //--------------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------------
  localparam int addressBits = 3;                           // Bits in an array handle
  localparam int indexBits   = 3;                           // Bits in an element index
  localparam int arrayLength = 2 ** indexBits;              // Elements per array
  localparam int arrayCount  = 2 ** addressBits;            // Arrays in the heap
  localparam int dataBits    = 16;                          // Width of one element

  //--------------------------------------------------------------------------
  // Types
  //--------------------------------------------------------------------------
  typedef logic [addressBits-1:0] arrayHandle;              // Names one array
  typedef logic [indexBits-1:0]   elementIndex;             // Element within an array
  typedef logic [indexBits:0]     arraySize;                // 0 to arrayLength inclusive
  typedef logic [dataBits-1:0]    elementData;              // One element

endpackage

// File: hw/heapMemory.sv
// Heap memory top level
// Connects the controller to the allocator, the size table and the element ALU

module heapMemory (
  input  logic                        clock,
  input  logic                        reset,
  input  heapCommandPkg::heapRequest  request,
  output heapCommandPkg::heapResponse response
);

  logic                        live;
  logic                        fresh;
  logic                        exhausted;
  logic                        allocate;
  logic                        releaseHandle;
  logic                        clear;
  heapGeometryPkg::arrayHandle grantHandle;
  heapGeometryPkg::arrayHandle queryHandle;
  heapGeometryPkg::arrayHandle sizeHandle;
  heapGeometryPkg::arraySize   currentSize;
  heapGeometryPkg::arraySize   sizeValue;
  heapCommandPkg::sizeUpdate   sizeOp;
  heapGeometryPkg::elementData storedElement;
  heapGeometryPkg::elementData aluElement;
  heapGeometryPkg::elementData aluReport;

  heapController heapController_inst (.*);                  // Decode, checks, storage

  heapAllocator heapAllocator_inst (.*);                    // Handle bookkeeping

  heapSizeTable heapSizeTable_inst (
    .clock, .reset, .sizeOp, .sizeHandle, .sizeValue,
    .readHandle (request.array),                            // Size seen by the checks
    .currentSize
  );

  heapElementAlu heapElementAlu_inst (
    .action     (request.action),
    .element    (storedElement),
    .operand    (request.data),
    .newElement (aluElement),
    .report     (aluReport)
  );

endmodule

// File: hw/heapSizeTable.sv
// Array size table
// One size per array, one update per cycle, combinational read for the checks

module heapSizeTable (
  input  logic                        clock,
  input  logic                        reset,
  input  heapCommandPkg::sizeUpdate   sizeOp,
  input  heapGeometryPkg::arrayHandle sizeHandle,          // Array to update
  input  heapGeometryPkg::arraySize   sizeValue,           // Used by setValue
  input  heapGeometryPkg::arrayHandle readHandle,
  output heapGeometryPkg::arraySize   currentSize
);

  heapGeometryPkg::arraySize sizes [heapGeometryPkg::arrayCount];

  assign currentSize = sizes[readHandle];                   // Present size, no delay

  //--------------------------------------------------------------------------
  // Update
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      sizes <= '{default: '0};
    end else begin
      case (sizeOp)
        heapCommandPkg::setValue:  sizes[sizeHandle] <= sizeValue;
        heapCommandPkg::increment: sizes[sizeHandle] <= sizes[sizeHandle] + 1'b1;
        heapCommandPkg::decrement: sizes[sizeHandle] <= sizes[sizeHandle] - 1'b1;
        heapCommandPkg::zero:      sizes[sizeHandle] <= '0; // Fresh or reused array
        default: ;                                          // Keep
      endcase
    end
  end

endmodule

// File: tests/heapMemoryTb.sv
// Heap memory testbench
// Reference model of arrays, sizes and the freed stack, directed and random
// stimulus, and assertion checks of every response

module heapMemoryTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockPeriod    = 8;
  localparam int resetCycles    = 5;
  localparam int directedCycles = 100;                      // Upper bound of directed phases
  localparam int randomCount    = 200;                      // One command per sweep step
  localparam int timeoutCycles  = resetCycles + directedCycles + randomCount + 20;

  logic                        clock = 1'b0;
  logic                        reset;
  heapCommandPkg::heapRequest  request;
  heapCommandPkg::heapResponse response;

  // Reference model
  heapGeometryPkg::elementData  elements [8][8];
  int                           sizes [8];
  bit                           live [8];
  int                           issued;                     // Handles ever given out
  heapGeometryPkg::arrayHandle  freedStack [$];             // Back is the top
  heapGeometryPkg::elementData  lastData;
  heapCommandPkg::heapError     lastError;
  int                           failures = 0;
  int                           seed = 32'h69c8_0fca;

  heapCommandPkg::heapAction arithActions [10] = '{
    heapCommandPkg::add, heapCommandPkg::addAfter, heapCommandPkg::subtract,
    heapCommandPkg::subAfter, heapCommandPkg::shiftLeft, heapCommandPkg::shiftRight,
    heapCommandPkg::bitNot, heapCommandPkg::bitOr, heapCommandPkg::bitXor,
    heapCommandPkg::bitAnd};

  heapMemory heapMemory_inst (.clock, .reset, .request, .response);

  always #(clockPeriod / 2) clock = ~clock;

  //--------------------------------------------------------------------------
  // Watchdog
  //--------------------------------------------------------------------------
  initial begin
    #(timeoutCycles * clockPeriod);
    $display("Timeout: the test sequence did not finish within %0d cycles", timeoutCycles);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  task automatic reportMismatch(input string name, input logic [15:0] got,
                                input logic [15:0] want);
    failures++;
    $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, want);
    $display("Checks failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  function automatic bit isArithmetic(input heapCommandPkg::heapAction action);
    foreach (arithActions[i]) begin
      if (arithActions[i] == action) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Element result of one in-place action
  function automatic heapGeometryPkg::elementData arithResult(
      input heapCommandPkg::heapAction action, input heapGeometryPkg::elementData value,
      input heapGeometryPkg::elementData operand);
    case (action)
      heapCommandPkg::add, heapCommandPkg::addAfter:      return value + operand;
      heapCommandPkg::subtract, heapCommandPkg::subAfter: return value - operand;
      heapCommandPkg::shiftLeft:  return (operand >= 16) ? 16'h0 : value << operand;
      heapCommandPkg::shiftRight: return (operand >= 16) ? 16'h0 : value >> operand;
      heapCommandPkg::bitNot:     return ~value;
      heapCommandPkg::bitOr:      return value | operand;
      heapCommandPkg::bitXor:     return value ^ operand;
      heapCommandPkg::bitAnd:     return value & operand;
      default:                    return value;
    endcase
  endfunction

  // Error rules in priority order
  function automatic heapCommandPkg::heapError findError(
      input heapCommandPkg::heapAction action, input int array, input int index,
      input heapGeometryPkg::elementData data);
    bit handleChecked;
    handleChecked = !(action inside {heapCommandPkg::idle, heapCommandPkg::clearAll,
                                     heapCommandPkg::alloc});
    if (handleChecked && array >= issued) return heapCommandPkg::notAllocated;
    if (handleChecked && !live[array]) return heapCommandPkg::freed;
    if ((isArithmetic(action) || action == heapCommandPkg::read) && index >= sizes[array])
      return heapCommandPkg::outOfBounds;
    if (action == heapCommandPkg::push && sizes[array] == 8) return heapCommandPkg::full;
    if (action == heapCommandPkg::pop && sizes[array] == 0) return heapCommandPkg::empty;
    if (action == heapCommandPkg::resize && data > 8) return heapCommandPkg::tooLarge;
    if (action == heapCommandPkg::alloc && freedStack.size() == 0 && issued == 8)
      return heapCommandPkg::outOfMemory;
    return heapCommandPkg::none;
  endfunction

  //--------------------------------------------------------------------------
  // One command: drive at the falling edge, check after the rising edge
  //--------------------------------------------------------------------------
  task automatic runCommand(input heapCommandPkg::heapAction action, input int array,
                            input int index, input heapGeometryPkg::elementData data);
    heapCommandPkg::heapError    wantError;
    heapGeometryPkg::elementData wantData;
    heapGeometryPkg::elementData oldValue;
    heapGeometryPkg::elementData newValue;
    int                          grant;
    oldValue  = elements[array][index];
    newValue  = arithResult(action, oldValue, data);
    grant     = (freedStack.size() != 0) ? int'(freedStack[$]) : issued;
    wantError = findError(action, array, index, data);
    wantData  = lastData;                                   // Held unless a result is due
    if (action == heapCommandPkg::idle) wantError = lastError;
    if (wantError == heapCommandPkg::none) begin
      case (action)
        heapCommandPkg::write: wantData = data;
        heapCommandPkg::read:  wantData = oldValue;
        heapCommandPkg::size:  wantData = 16'(sizes[array]);
        heapCommandPkg::pop:   wantData = elements[array][sizes[array] - 1];
        heapCommandPkg::alloc: wantData = 16'(grant);
        heapCommandPkg::addAfter, heapCommandPkg::subAfter: wantData = oldValue;
        default: if (isArithmetic(action)) wantData = newValue;
      endcase
    end
    request = '{action: action, array: 3'(array), index: 3'(index), data: data};
    @(posedge clock);
    @(negedge clock);                                       // Response settled
    assert (response.error == wantError)
      else reportMismatch("response.error", 16'(response.error), 16'(wantError));
    assert (response.data == wantData)
      else reportMismatch("response.data", response.data, wantData);
    if (wantError == heapCommandPkg::none) begin
      case (action)
        heapCommandPkg::clearAll: begin
          issued = 0;
          freedStack.delete();
          foreach (live[i]) live[i] = 0;
        end
        heapCommandPkg::write: begin
          elements[array][index] = data;
          if (index >= sizes[array]) sizes[array] = index + 1;  // Grows to index+1
        end
        heapCommandPkg::push: begin
          elements[array][sizes[array]] = data;
          sizes[array]++;
        end
        heapCommandPkg::pop:    sizes[array]--;
        heapCommandPkg::resize: sizes[array] = int'(data);
        heapCommandPkg::alloc: begin
          if (freedStack.size() != 0) void'(freedStack.pop_back());
          else issued++;
          live[grant]  = 1;
          sizes[grant] = 0;                                 // Reused arrays start empty
        end
        heapCommandPkg::free: begin
          live[array] = 0;
          freedStack.push_back(3'(array));
        end
        default: if (isArithmetic(action)) elements[array][index] = newValue;
      endcase
    end
    lastData  = wantData;
    lastError = wantError;
  endtask

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------
  initial begin
    heapCommandPkg::heapAction pick;
    heapGeometryPkg::elementData operand;
    request   = '0;
    reset     = 1'b1;
    issued    = 0;
    lastData  = '0;
    lastError = heapCommandPkg::none;
    foreach (sizes[i]) sizes[i] = 0;
    foreach (live[i]) live[i] = 0;
    foreach (elements[i, j]) elements[i][j] = '0;
    repeat (resetCycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    assert (response.data == 16'h0) else reportMismatch("response.data", response.data, 16'h0);
    assert (response.error == heapCommandPkg::none)
      else reportMismatch("response.error", 16'(response.error), 16'h0);

    runCommand(heapCommandPkg::read, 4, 0, 16'h0);          // Never handed out
    repeat (3) runCommand(heapCommandPkg::idle, 0, 0, 16'hffff);  // Response holds
    repeat (9) runCommand(heapCommandPkg::alloc, 0, 0, 16'h0);    // 0 to 7, then no memory

    // Write, read, size, resize
    runCommand(heapCommandPkg::write, 0, 5, 16'hbeef);
    runCommand(heapCommandPkg::size, 0, 0, 16'h0);
    runCommand(heapCommandPkg::read, 0, 5, 16'h0);
    runCommand(heapCommandPkg::read, 0, 6, 16'h0);
    runCommand(heapCommandPkg::resize, 0, 0, 16'd9);
    runCommand(heapCommandPkg::resize, 0, 0, 16'd2);
    runCommand(heapCommandPkg::size, 0, 0, 16'h0);

    // Push and pop on array 1
    runCommand(heapCommandPkg::push, 1, 0, 16'd1);
    runCommand(heapCommandPkg::push, 1, 0, 16'd2);
    repeat (3) runCommand(heapCommandPkg::pop, 1, 0, 16'h0);  // 2, 1, then empty
    for (int k = 0; k < 9; k++) runCommand(heapCommandPkg::push, 1, 0, 16'(k + 16'h100));

    // Lifetime errors and reuse order
    runCommand(heapCommandPkg::write, 3, 4, 16'h1234);
    runCommand(heapCommandPkg::write, 2, 1, 16'h5678);      // Nonzero size before reuse
    runCommand(heapCommandPkg::free, 2, 0, 16'h0);
    runCommand(heapCommandPkg::free, 2, 0, 16'h0);
    runCommand(heapCommandPkg::read, 2, 0, 16'h0);
    runCommand(heapCommandPkg::free, 3, 0, 16'h0);
    runCommand(heapCommandPkg::alloc, 0, 0, 16'h0);         // Reuses 3
    runCommand(heapCommandPkg::size, 3, 0, 16'h0);
    runCommand(heapCommandPkg::alloc, 0, 0, 16'h0);         // Reuses 2
    runCommand(heapCommandPkg::size, 2, 0, 16'h0);

    // Arithmetic, fill array 4 first
    for (int k = 0; k < 8; k++) runCommand(heapCommandPkg::write, 4, k, 16'($random(seed)));
    runCommand(heapCommandPkg::add, 4, 2, 16'h0011);        // Back to back on one element
    runCommand(heapCommandPkg::addAfter, 4, 2, 16'h0101);
    runCommand(heapCommandPkg::subAfter, 4, 2, 16'h0022);
    runCommand(heapCommandPkg::bitNot, 4, 2, 16'h0);
    runCommand(heapCommandPkg::shiftLeft, 4, 2, 16'd17);
    for (int k = 0; k < randomCount; k++) begin
      pick    = arithActions[($random(seed) & 32'h7fff_ffff) % 10];
      operand = 16'($random(seed));
      if (pick inside {heapCommandPkg::shiftLeft, heapCommandPkg::shiftRight}) begin
        operand = operand & 16'h001f;                       // Some shifts reach 16 or more
      end
      runCommand(pick, 4, $random(seed) & 7, operand);
    end

    // Clear makes every handle unknown again
    runCommand(heapCommandPkg::clearAll, 0, 0, 16'h0);
    for (int k = 0; k < 8; k++) runCommand(heapCommandPkg::size, k, 0, 16'h0);
    repeat (2) runCommand(heapCommandPkg::idle, 0, 0, 16'h0);

    if (failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
